//--- hdl/rv_pkg.sv
// rv_pkg: shared widths, encodings and CSR constants for the RV32I core
package rv_pkg;

	// datapath and register index widths
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	// first fetch address after reset
	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

	// major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		opc_op_imm = 7'b001_0011,
		opc_op_reg = 7'b011_0011,
		opc_lui    = 7'b011_0111,
		opc_auipc  = 7'b001_0111,
		opc_jal    = 7'b110_1111,
		opc_jalr   = 7'b110_0111,
		opc_branch = 7'b110_0011,
		opc_load   = 7'b000_0011,
		opc_store  = 7'b010_0011,
		opc_system = 7'b111_0011
	} opcode_e;

	// ALU operations
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_sltu,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b
	} alu_op_e;

	// conditional branch compares
	typedef enum logic [2:0] {
		br_none,
		br_beq,
		br_bne,
		br_blt,
		br_bge,
		br_bltu,
		br_bgeu
	} br_op_e;

	// access size, encoded like funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		mem_byte = 2'b00,
		mem_half = 2'b01,
		mem_word = 2'b10
	} mem_size_e;

	// source of the register write-back
	typedef enum logic [2:0] {
		wb_none,
		wb_alu,
		wb_load,
		wb_pc_plus4,
		wb_csr
	} wb_sel_e;

	// machine-mode CSR addresses
	localparam logic [11:0] csr_mtvec   = 12'h305;
	localparam logic [11:0] csr_mepc    = 12'h341;
	localparam logic [11:0] csr_mcause  = 12'h342;
	localparam logic [11:0] csr_mstatus = 12'h300;

	// environment call from M-mode
	localparam logic [xlen-1:0] cause_ecall_m = 32'd11;

endpackage

//--- hdl/reg_file.sv
// reg_file: 32-entry integer register file, two async reads, one write, x0 tied to zero
`timescale 1ns/1ps

module reg_file (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
	input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
	output logic [rv_pkg::xlen-1:0]       rdata1,
	output logic [rv_pkg::xlen-1:0]       rdata2,
	input  logic [rv_pkg::reg_addr_w-1:0] waddr,
	input  logic [rv_pkg::xlen-1:0]       wdata,
	input  logic                          wen
);

	// x0 has no storage
	logic [rv_pkg::xlen-1:0] regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hdl/csr_file.sv
// csr_file: machine-mode CSRs with ecall trap update and read mux
`timescale 1ns/1ps

module csr_file (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [11:0]             csr_addr,
	input  logic                    csr_we,
	input  logic [rv_pkg::xlen-1:0] wdata,
	input  logic                    ecall,
	input  logic [rv_pkg::xlen-1:0] epc,
	output logic [rv_pkg::xlen-1:0] rdata,
	output logic [rv_pkg::xlen-1:0] mtvec,
	output logic [rv_pkg::xlen-1:0] mepc
);

	logic [rv_pkg::xlen-1:0] mcause;
	logic [rv_pkg::xlen-1:0] mstatus;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
			mstatus <= '0;
		end else if (ecall) begin
			// trap entry takes priority over any csr write
			mepc   <= epc;
			mcause <= rv_pkg::cause_ecall_m;
		end else if (csr_we) begin
			case (csr_addr)
				rv_pkg::csr_mtvec:   mtvec   <= wdata;
				rv_pkg::csr_mepc:    mepc    <= wdata;
				rv_pkg::csr_mcause:  mcause  <= wdata;
				rv_pkg::csr_mstatus: mstatus <= wdata;
				default: ;
			endcase
		end
	end

	// unknown addresses read as zero
	always_comb begin
		case (csr_addr)
			rv_pkg::csr_mtvec:   rdata = mtvec;
			rv_pkg::csr_mepc:    rdata = mepc;
			rv_pkg::csr_mcause:  rdata = mcause;
			rv_pkg::csr_mstatus: rdata = mstatus;
			default:             rdata = '0;
		endcase
	end

endmodule

//--- hdl/inst_decode.sv
// inst_decode: decodes RV32I instructions, builds immediates and ALU operands
`timescale 1ns/1ps

module inst_decode (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [rv_pkg::xlen-1:0]       inst,
	input  logic [rv_pkg::xlen-1:0]       pc,
	input  logic                          halted,
	input  logic                          rd_wen,
	input  logic [rv_pkg::xlen-1:0]       rd_wdata,
	input  logic [rv_pkg::xlen-1:0]       csr_wdata,
	output logic [rv_pkg::xlen-1:0]       src1,
	output logic [rv_pkg::xlen-1:0]       src2,
	output rv_pkg::alu_op_e               alu_op,
	output rv_pkg::br_op_e                br_op,
	output logic [rv_pkg::xlen-1:0]       branch_target,
	output logic                          jump,
	output logic                          jump_reg,
	output logic                          trap_taken,
	output logic [rv_pkg::xlen-1:0]       trap_target,
	output logic                          halt,
	output logic                          mem_read,
	output logic                          mem_write,
	output rv_pkg::mem_size_e             mem_size,
	output logic                          mem_unsigned,
	output logic [rv_pkg::xlen-1:0]       store_data,
	output rv_pkg::wb_sel_e               wb_sel,
	output logic [rv_pkg::reg_addr_w-1:0] rd_addr,
	output logic [rv_pkg::xlen-1:0]       csr_rdata
);

	rv_pkg::opcode_e         opcode;
	logic [2:0]              funct3;
	logic [6:0]              funct7;
	logic [11:0]             csr_addr;
	logic [rv_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [rv_pkg::xlen-1:0] imm;
	logic [rv_pkg::xlen-1:0] rs1_data, rs2_data;
	logic [rv_pkg::xlen-1:0] mtvec, mepc;
	logic                    is_csrrw, is_csrrs, is_ecall, is_ebreak, is_mret;

	assign opcode   = rv_pkg::opcode_e'(inst[6:0]);
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign rd_addr  = inst[11:7];
	assign csr_addr = inst[31:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// system instructions are matched on the whole word
	assign is_csrrw  = (opcode == rv_pkg::opc_system) && (funct3 == 3'b001);
	assign is_csrrs  = (opcode == rv_pkg::opc_system) && (funct3 == 3'b010);
	assign is_ecall  = (inst == 32'h0000_0073);
	assign is_ebreak = (inst == 32'h0010_0073);
	assign is_mret   = (inst == 32'h3020_0073);

	reg_file i_reg_file (
		.clk    (clk),
		.arst_n (arst_n),
		.raddr1 (inst[19:15]),
		.raddr2 (inst[24:20]),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data),
		.waddr  (rd_addr),
		.wdata  (rd_wdata),
		.wen    (rd_wen)
	);

	// nothing reaches the CSRs once the core has stopped
	csr_file i_csr_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.csr_addr (csr_addr),
		.csr_we   ((is_csrrw | is_csrrs) & ~halted),
		.wdata    (csr_wdata),
		.ecall    (is_ecall & ~halted),
		.epc      (pc),
		.rdata    (csr_rdata),
		.mtvec    (mtvec),
		.mepc     (mepc)
	);

	always_comb begin
		case (opcode)
			rv_pkg::opc_store:                   imm = imm_s;
			rv_pkg::opc_lui, rv_pkg::opc_auipc:  imm = imm_u;
			rv_pkg::opc_jal:                     imm = imm_j;
			default:                             imm = imm_i;
		endcase
	end

	// lui adds its immediate to zero
	always_comb begin
		case (opcode)
			rv_pkg::opc_auipc, rv_pkg::opc_jal: src1 = pc;
			rv_pkg::opc_lui:                    src1 = '0;
			default:                            src1 = rs1_data;
		endcase
	end

	// csrrw passes rs1 through src2 so the ALU can forward it
	always_comb begin
		case (opcode)
			rv_pkg::opc_op_imm, rv_pkg::opc_lui, rv_pkg::opc_auipc,
			rv_pkg::opc_jal, rv_pkg::opc_jalr, rv_pkg::opc_load,
			rv_pkg::opc_store:  src2 = imm;
			rv_pkg::opc_system: src2 = is_csrrw ? rs1_data : csr_rdata;
			default:            src2 = rs2_data;
		endcase
	end

	always_comb begin
		alu_op = rv_pkg::alu_add;
		if (opcode == rv_pkg::opc_op_imm || opcode == rv_pkg::opc_op_reg) begin
			case (funct3)
				3'b000: alu_op = (opcode == rv_pkg::opc_op_reg && funct7[5]) ?
						rv_pkg::alu_sub : rv_pkg::alu_add;
				3'b001: alu_op = rv_pkg::alu_sll;
				3'b010: alu_op = rv_pkg::alu_slt;
				3'b011: alu_op = rv_pkg::alu_sltu;
				3'b100: alu_op = rv_pkg::alu_xor;
				3'b101: alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
				3'b110: alu_op = rv_pkg::alu_or;
				default: alu_op = rv_pkg::alu_and;
			endcase
		end else if (is_csrrw) begin
			alu_op = rv_pkg::alu_pass_b;
		end else if (is_csrrs) begin
			alu_op = rv_pkg::alu_or;
		end
	end

	always_comb begin
		br_op = rv_pkg::br_none;
		if (opcode == rv_pkg::opc_branch) begin
			case (funct3)
				3'b000:  br_op = rv_pkg::br_beq;
				3'b001:  br_op = rv_pkg::br_bne;
				3'b100:  br_op = rv_pkg::br_blt;
				3'b101:  br_op = rv_pkg::br_bge;
				3'b110:  br_op = rv_pkg::br_bltu;
				3'b111:  br_op = rv_pkg::br_bgeu;
				default: br_op = rv_pkg::br_none;
			endcase
		end
	end

	always_comb begin
		case (opcode)
			rv_pkg::opc_op_imm, rv_pkg::opc_op_reg,
			rv_pkg::opc_lui, rv_pkg::opc_auipc:  wb_sel = rv_pkg::wb_alu;
			rv_pkg::opc_load:                    wb_sel = rv_pkg::wb_load;
			rv_pkg::opc_jal, rv_pkg::opc_jalr:   wb_sel = rv_pkg::wb_pc_plus4;
			rv_pkg::opc_system: wb_sel = (is_csrrw | is_csrrs) ? rv_pkg::wb_csr
					: rv_pkg::wb_none;
			default:                             wb_sel = rv_pkg::wb_none;
		endcase
	end

	assign branch_target = pc + imm_b;
	assign jump          = (opcode == rv_pkg::opc_jal) || (opcode == rv_pkg::opc_jalr);
	assign jump_reg      = (opcode == rv_pkg::opc_jalr);

	// ecall enters the handler, mret returns to the saved pc
	assign trap_taken  = is_ecall | is_mret;
	assign trap_target = is_ecall ? mtvec : mepc;
	assign halt        = is_ebreak;

	assign mem_read     = (opcode == rv_pkg::opc_load);
	assign mem_write    = (opcode == rv_pkg::opc_store);
	assign mem_size     = rv_pkg::mem_size_e'(funct3[1:0]);
	assign mem_unsigned = funct3[2];
	assign store_data   = rs2_data;

endmodule

//--- hdl/alu_execute.sv
// alu_execute: ALU, branch compare, next-pc select and the pc register
`timescale 1ns/1ps

module alu_execute (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [rv_pkg::xlen-1:0] src1,
	input  logic [rv_pkg::xlen-1:0] src2,
	input  rv_pkg::alu_op_e         alu_op,
	input  rv_pkg::br_op_e          br_op,
	input  logic [rv_pkg::xlen-1:0] branch_target,
	input  logic                    jump,
	input  logic                    jump_reg,
	input  logic                    trap_taken,
	input  logic [rv_pkg::xlen-1:0] trap_target,
	input  logic                    halt,
	output logic [rv_pkg::xlen-1:0] alu_result,
	output logic [rv_pkg::xlen-1:0] pc_plus4,
	output logic [rv_pkg::xlen-1:0] pc,
	output logic                    halted
);

	logic [4:0]              shamt;
	logic                    br_taken;
	logic [rv_pkg::xlen-1:0] jump_target;
	logic [rv_pkg::xlen-1:0] pc_next;

	assign shamt = src2[4:0];

	always_comb begin
		case (alu_op)
			rv_pkg::alu_sub:    alu_result = src1 - src2;
			rv_pkg::alu_slt:    alu_result = {31'b0, $signed(src1) < $signed(src2)};
			rv_pkg::alu_sltu:   alu_result = {31'b0, src1 < src2};
			rv_pkg::alu_and:    alu_result = src1 & src2;
			rv_pkg::alu_or:     alu_result = src1 | src2;
			rv_pkg::alu_xor:    alu_result = src1 ^ src2;
			rv_pkg::alu_sll:    alu_result = src1 << shamt;
			rv_pkg::alu_srl:    alu_result = src1 >> shamt;
			rv_pkg::alu_sra:    alu_result = $signed(src1) >>> shamt;
			rv_pkg::alu_pass_b: alu_result = src2;
			default:            alu_result = src1 + src2;
		endcase
	end

	always_comb begin
		case (br_op)
			rv_pkg::br_beq:  br_taken = (src1 == src2);
			rv_pkg::br_bne:  br_taken = (src1 != src2);
			rv_pkg::br_blt:  br_taken = ($signed(src1) < $signed(src2));
			rv_pkg::br_bge:  br_taken = ($signed(src1) >= $signed(src2));
			rv_pkg::br_bltu: br_taken = (src1 < src2);
			rv_pkg::br_bgeu: br_taken = (src1 >= src2);
			default:         br_taken = 1'b0;
		endcase
	end

	// jalr drops bit 0 of the computed target
	assign jump_target = jump_reg ? {alu_result[rv_pkg::xlen-1:1], 1'b0} : alu_result;
	assign pc_plus4    = pc + 32'd4;

	always_comb begin
		if (trap_taken)
			pc_next = trap_target;
		else if (jump)
			pc_next = jump_target;
		else if (br_taken)
			pc_next = branch_target;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc     <= rv_pkg::reset_pc;
			halted <= 1'b0;
		end else if (!halted) begin
			pc     <= pc_next;
			halted <= halt;
		end
	end

endmodule

//--- hdl/result_writeback.sv
// result_writeback: store lane placement, load extension and write-back select
`timescale 1ns/1ps

module result_writeback (
	input  logic [rv_pkg::xlen-1:0]       alu_result,
	input  logic [rv_pkg::xlen-1:0]       pc_plus4,
	input  logic [rv_pkg::xlen-1:0]       csr_rdata,
	input  logic                          mem_read,
	input  logic                          mem_write,
	input  rv_pkg::mem_size_e             mem_size,
	input  logic                          mem_unsigned,
	input  logic [rv_pkg::xlen-1:0]       store_data,
	input  rv_pkg::wb_sel_e               wb_sel,
	input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
	input  logic                          halted,
	input  logic [rv_pkg::xlen-1:0]       dmem_rdata,
	output logic [rv_pkg::xlen-1:0]       dmem_addr,
	output logic [rv_pkg::xlen-1:0]       dmem_wdata,
	output logic [3:0]                    dmem_wmask,
	output logic                          dmem_wen,
	output logic                          rd_wen,
	output logic [rv_pkg::xlen-1:0]       rd_wdata,
	output logic [rv_pkg::xlen-1:0]       csr_wdata
);

	logic [1:0]              offset;
	logic [rv_pkg::xlen-1:0] shifted;
	logic [rv_pkg::xlen-1:0] load_data;

	assign dmem_addr = alu_result;
	assign offset    = alu_result[1:0];

	// replicate the store data so every lane carries it, mask picks the lanes
	always_comb begin
		case (mem_size)
			rv_pkg::mem_byte: begin
				dmem_wdata = {4{store_data[7:0]}};
				dmem_wmask = 4'b0001 << offset;
			end
			rv_pkg::mem_half: begin
				dmem_wdata = {2{store_data[15:0]}};
				dmem_wmask = 4'b0011 << {offset[1], 1'b0};
			end
			default: begin
				dmem_wdata = store_data;
				dmem_wmask = 4'b1111;
			end
		endcase
	end

	assign dmem_wen = mem_write & ~halted;

	// bring the addressed byte or half down to bit 0
	assign shifted = dmem_rdata >> {offset, 3'b000};

	always_comb begin
		load_data = '0;
		if (mem_read) begin
			case (mem_size)
				rv_pkg::mem_byte:
					load_data = {{24{~mem_unsigned & shifted[7]}}, shifted[7:0]};
				rv_pkg::mem_half:
					load_data = {{16{~mem_unsigned & shifted[15]}}, shifted[15:0]};
				default:
					load_data = dmem_rdata;
			endcase
		end
	end

	always_comb begin
		case (wb_sel)
			rv_pkg::wb_alu:      rd_wdata = alu_result;
			rv_pkg::wb_load:     rd_wdata = load_data;
			rv_pkg::wb_pc_plus4: rd_wdata = pc_plus4;
			rv_pkg::wb_csr:      rd_wdata = csr_rdata;
			default:             rd_wdata = '0;
		endcase
	end

	assign rd_wen    = (wb_sel != rv_pkg::wb_none) && (rd_addr != '0) && !halted;
	assign csr_wdata = alu_result;

endmodule

//--- hdl/rv_core.sv
// rv_core: single-cycle RV32I core top, decode, execute and write-back stages
`timescale 1ns/1ps

module rv_core (
	input  logic                          clk,
	input  logic                          arst_n,
	output logic [rv_pkg::xlen-1:0]       imem_addr,
	input  logic [rv_pkg::xlen-1:0]       imem_rdata,
	output logic [rv_pkg::xlen-1:0]       dmem_addr,
	output logic [rv_pkg::xlen-1:0]       dmem_wdata,
	output logic [3:0]                    dmem_wmask,
	output logic                          dmem_wen,
	input  logic [rv_pkg::xlen-1:0]       dmem_rdata,
	output logic                          retire,
	output logic [rv_pkg::xlen-1:0]       retire_pc,
	output logic                          rd_wen,
	output logic [rv_pkg::reg_addr_w-1:0] rd_addr,
	output logic [rv_pkg::xlen-1:0]       rd_wdata,
	output logic                          halted
);

	logic [rv_pkg::xlen-1:0] pc, pc_plus4, alu_result;
	logic [rv_pkg::xlen-1:0] src1, src2, branch_target, trap_target;
	logic [rv_pkg::xlen-1:0] store_data, csr_rdata, csr_wdata;
	rv_pkg::alu_op_e         alu_op;
	rv_pkg::br_op_e          br_op;
	rv_pkg::mem_size_e       mem_size;
	rv_pkg::wb_sel_e         wb_sel;
	logic                    jump, jump_reg, trap_taken, halt;
	logic                    mem_read, mem_write, mem_unsigned;
	logic                    idle;

	// nothing retires while in reset or after ebreak
	assign idle      = halted | ~arst_n;
	assign retire    = ~idle;
	assign imem_addr = pc;
	assign retire_pc = pc;

	inst_decode i_inst_decode (
		.clk (clk), .arst_n (arst_n), .inst (imem_rdata), .pc (pc), .halted (idle),
		.rd_wen (rd_wen), .rd_wdata (rd_wdata), .csr_wdata (csr_wdata),
		.src1 (src1), .src2 (src2), .alu_op (alu_op), .br_op (br_op),
		.branch_target (branch_target), .jump (jump), .jump_reg (jump_reg),
		.trap_taken (trap_taken), .trap_target (trap_target), .halt (halt),
		.mem_read (mem_read), .mem_write (mem_write), .mem_size (mem_size),
		.mem_unsigned (mem_unsigned), .store_data (store_data), .wb_sel (wb_sel),
		.rd_addr (rd_addr), .csr_rdata (csr_rdata)
	);

	alu_execute i_alu_execute (
		.clk (clk), .arst_n (arst_n), .src1 (src1), .src2 (src2), .alu_op (alu_op),
		.br_op (br_op), .branch_target (branch_target), .jump (jump),
		.jump_reg (jump_reg), .trap_taken (trap_taken), .trap_target (trap_target),
		.halt (halt), .alu_result (alu_result), .pc_plus4 (pc_plus4), .pc (pc),
		.halted (halted)
	);

	result_writeback i_result_writeback (
		.alu_result (alu_result), .pc_plus4 (pc_plus4), .csr_rdata (csr_rdata),
		.mem_read (mem_read), .mem_write (mem_write), .mem_size (mem_size),
		.mem_unsigned (mem_unsigned), .store_data (store_data), .wb_sel (wb_sel),
		.rd_addr (rd_addr), .halted (idle), .dmem_rdata (dmem_rdata),
		.dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata), .dmem_wmask (dmem_wmask),
		.dmem_wen (dmem_wen), .rd_wen (rd_wen), .rd_wdata (rd_wdata),
		.csr_wdata (csr_wdata)
	);

endmodule

//--- tests/tb_clock.sv
// tb_clock: free-running testbench clock, 20 ns period
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

endmodule

//--- tests/tb_top.sv
// tb_top: testbench for rv_core with memory models, reference model and checks
`timescale 1ns/1ps

module tb_top;

	localparam int imem_words  = 64;
	localparam int dmem_words  = 256;
	localparam int n_tests     = 6;
	// reset, a full program and the halt window per test
	localparam int test_cycles = 16 + imem_words + 12;
	localparam int watchdog_ns = n_tests * test_cycles * 20 + 1000;

	logic        clk;
	logic        arst_n;
	logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
	logic [3:0]  dmem_wmask;
	logic        dmem_wen, retire, rd_wen, halted;
	logic [31:0] retire_pc, rd_wdata;
	logic [4:0]  rd_addr;

	logic [31:0] imem [0:imem_words-1];
	logic [31:0] dmem [0:dmem_words-1];
	int          prog_len;

	// reference model state
	logic [31:0] m_pc;
	logic [31:0] m_x [0:31];
	logic [31:0] m_dmem [0:dmem_words-1];
	logic [31:0] m_mtvec, m_mepc, m_mcause, m_mstatus;
	logic        m_halted;
	logic [31:0] rng_state;
	int          errors, checks;

	tb_clock i_tb_clock (.clk (clk));

	rv_core i_rv_core (
		.clk (clk), .arst_n (arst_n), .imem_addr (imem_addr), .imem_rdata (imem_rdata),
		.dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata), .dmem_wmask (dmem_wmask),
		.dmem_wen (dmem_wen), .dmem_rdata (dmem_rdata), .retire (retire),
		.retire_pc (retire_pc), .rd_wen (rd_wen), .rd_addr (rd_addr),
		.rd_wdata (rd_wdata), .halted (halted)
	);

	assign imem_rdata = imem[imem_addr[7:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// data region starts at 0x1000
	function automatic logic [31:0] fill_word(int i);
		logic [31:0] addr;
		addr = 32'h1000 + 32'(i) * 4;
		return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic [31:0] byte_bits(logic [3:0] m);
		return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	always @(posedge clk) begin
		if (!arst_n) begin
			for (int i = 0; i < dmem_words; i++) begin
				dmem[i] <= fill_word(i);
			end
		end else if (dmem_wen) begin
			for (int i = 0; i < 4; i++) begin
				if (dmem_wmask[i])
					dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
			end
		end
	end

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail at %0t ns: %s is %08h, expected %08h", $time, name, got, exp);
		end
	endtask

	// instruction encoders
	function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	task automatic emit(logic [31:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic load_const(logic [4:0] rd, logic [31:0] v);
		logic [31:0] hi;
		hi = (v + 32'h800) >> 12;
		emit({hi[19:0], rd, 7'h37});
		emit(i_type(v[11:0], rd, 3'd0, rd, 7'h13));
	endtask

	// unused words hold ebreak so a runaway pc stops the core
	task automatic clear_program();
		for (int i = 0; i < imem_words; i++) begin
			imem[i] = 32'h0010_0073;
		end
		prog_len = 0;
	endtask

	function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
			logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] csr_read(logic [11:0] addr);
		case (addr)
			12'h305: return m_mtvec;
			12'h341: return m_mepc;
			12'h342: return m_mcause;
			12'h300: return m_mstatus;
			default: return 32'd0;
		endcase
	endfunction

	task automatic csr_write(logic [11:0] addr, logic [31:0] v);
		case (addr)
			12'h305: m_mtvec = v;
			12'h341: m_mepc = v;
			12'h342: m_mcause = v;
			12'h300: m_mstatus = v;
			default: ;
		endcase
	endtask

	// executes one instruction in the model and compares the retire and memory ports
	task automatic model_step();
		logic [31:0] inst, a, b, nxt, wd, addr, word, lanes, old;
		logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [3:0]  mask;
		logic        wen, st, taken;
		inst  = imem[m_pc[7:2]];
		rd    = inst[11:7];
		f3    = inst[14:12];
		a     = m_x[inst[19:15]];
		b     = m_x[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_u = {inst[31:12], 12'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		nxt   = m_pc + 32'd4;
		wen   = 1'b0;
		st    = 1'b0;
		wd    = '0;
		addr  = '0;
		lanes = '0;
		mask  = '0;
		taken = 1'b0;
		check_value("retire_pc", retire_pc, m_pc);
		case (inst[6:0])
			7'h37: begin
				wen = 1'b1;
				wd  = imm_u;
			end
			7'h17: begin
				wen = 1'b1;
				wd  = m_pc + imm_u;
			end
			7'h6f: begin
				wen = 1'b1;
				wd  = m_pc + 32'd4;
				nxt = m_pc + imm_j;
			end
			7'h67: begin
				wen = 1'b1;
				wd  = m_pc + 32'd4;
				nxt = (a + imm_i) & ~32'd1;
			end
			7'h63: begin
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					3'd5: taken = ($signed(a) >= $signed(b));
					3'd6: taken = (a < b);
					3'd7: taken = (a >= b);
					default: taken = 1'b0;
				endcase
				if (taken)
					nxt = m_pc + imm_b;
			end
			7'h03: begin
				addr = a + imm_i;
				word = m_dmem[addr[9:2]] >> (8 * addr[1:0]);
				wen  = 1'b1;
				case (f3)
					3'd0: wd = {{24{word[7]}}, word[7:0]};
					3'd1: wd = {{16{word[15]}}, word[15:0]};
					3'd4: wd = {24'b0, word[7:0]};
					3'd5: wd = {16'b0, word[15:0]};
					default: wd = word;
				endcase
			end
			7'h23: begin
				addr  = a + imm_s;
				st    = 1'b1;
				lanes = b << (8 * addr[1:0]);
				case (f3)
					3'd0: mask = 4'b0001 << addr[1:0];
					3'd1: mask = 4'b0011 << addr[1:0];
					default: mask = 4'b1111;
				endcase
			end
			7'h13: begin
				wen = 1'b1;
				wd  = alu_ref(f3, inst[30] && f3 == 3'd5, a, imm_i);
			end
			7'h33: begin
				wen = 1'b1;
				wd  = alu_ref(f3, inst[30], a, b);
			end
			7'h73: begin
				if (inst == 32'h0000_0073) begin
					m_mepc   = m_pc;
					m_mcause = 32'd11;
					nxt      = m_mtvec;
				end else if (inst == 32'h3020_0073) begin
					nxt = m_mepc;
				end else if (inst == 32'h0010_0073) begin
					m_halted = 1'b1;
				end else if (f3 == 3'd1 || f3 == 3'd2) begin
					old = csr_read(inst[31:20]);
					wen = 1'b1;
					wd  = old;
					csr_write(inst[31:20], (f3 == 3'd1) ? a : (old | a));
				end
			end
			default: ;
		endcase
		// x0 is never written
		if (rd == 5'd0)
			wen = 1'b0;
		check_value("rd_wen", {31'b0, rd_wen}, {31'b0, wen});
		if (wen) begin
			check_value("rd_addr", {27'b0, rd_addr}, {27'b0, rd});
			check_value("rd_wdata", rd_wdata, wd);
			m_x[rd] = wd;
		end
		check_value("dmem_wen", {31'b0, dmem_wen}, {31'b0, st});
		if (st) begin
			check_value("dmem_addr", dmem_addr, addr);
			check_value("dmem_wmask", {28'b0, dmem_wmask}, {28'b0, mask});
			check_value("dmem_wdata", dmem_wdata & byte_bits(mask), lanes & byte_bits(mask));
			m_dmem[addr[9:2]] = (m_dmem[addr[9:2]] & ~byte_bits(mask)) | (lanes & byte_bits(mask));
		end
		m_pc = nxt;
	endtask

	// model and checks run on every rising edge
	always @(posedge clk) begin
		if (!arst_n) begin
			check_value("retire", {31'b0, retire}, 32'd0);
			check_value("rd_wen", {31'b0, rd_wen}, 32'd0);
			check_value("dmem_wen", {31'b0, dmem_wen}, 32'd0);
			check_value("halted", {31'b0, halted}, 32'd0);
			m_pc      = rv_pkg::reset_pc;
			m_mtvec   = '0;
			m_mepc    = '0;
			m_mcause  = '0;
			m_mstatus = '0;
			m_halted  = 1'b0;
			for (int i = 0; i < 32; i++) begin
				m_x[i] = '0;
			end
			for (int i = 0; i < dmem_words; i++) begin
				m_dmem[i] = fill_word(i);
			end
		end else if (m_halted) begin
			check_value("halted", {31'b0, halted}, 32'd1);
			check_value("retire", {31'b0, retire}, 32'd0);
			check_value("rd_wen", {31'b0, rd_wen}, 32'd0);
			check_value("dmem_wen", {31'b0, dmem_wen}, 32'd0);
			// pc holds at the word after ebreak
			check_value("imem_addr", imem_addr, m_pc);
		end else begin
			check_value("retire", {31'b0, retire}, 32'd1);
			check_value("halted", {31'b0, halted}, 32'd0);
			model_step();
		end
	end

	task automatic run_test(string name);
		int err0;
		err0 = errors;
		@(negedge clk);
		arst_n = 1'b0;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		while (!m_halted) @(negedge clk);
		repeat (8) @(negedge clk);
		$display("test %-8s %s, %0d errors", name, (errors == err0) ? "passed" : "failed",
			errors - err0);
	endtask

	task automatic build_arith();
		logic [31:0] v;
		for (int r = 1; r <= 4; r++) begin
			load_const(5'(r), lcg_next());
		end
		for (int k = 0; k < 8; k++) begin
			emit(r_type(7'h00, 5'd2, 5'd1, 3'(k), 5'(5 + k)));
		end
		emit(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd13));
		emit(r_type(7'h20, 5'd3, 5'd4, 3'd5, 5'd14));
		for (int k = 0; k < 8; k++) begin
			v = lcg_next();
			if (k == 1 || k == 5)
				v[11:5] = '0;
			emit(i_type(v[11:0], 5'(1 + k % 4), 3'(k), 5'(15 + k), 7'h13));
		end
		v = lcg_next();
		emit(i_type({7'h20, v[4:0]}, 5'd4, 3'd5, 5'd23, 7'h13));
		v = lcg_next();
		emit({v[19:0], 5'd24, 7'h37});
		emit({v[31:12], 5'd25, 7'h17});
		emit(i_type(12'd5, 5'd1, 3'd0, 5'd0, 7'h13));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
		emit(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd26));
		emit(32'h0010_0073);
	endtask

	task automatic build_control();
		logic [2:0] f3;
		load_const(5'd1, lcg_next() | 32'h8000_0000);
		load_const(5'd2, lcg_next() & 32'h7fff_ffff);
		for (int j = 0; j < 6; j++) begin
			f3 = (j < 2) ? 3'(j) : 3'(j + 2);
			emit(b_type(13'd8, 5'd2, 5'd1, f3));
			emit(i_type(12'd1, 5'd10, 3'd0, 5'd10, 7'h13));
			emit(b_type(13'd8, 5'd1, 5'd2, f3));
			emit(i_type(12'd1, 5'd10, 3'd0, 5'd10, 7'h13));
			emit(b_type(13'd8, 5'd1, 5'd1, f3));
			emit(i_type(12'd1, 5'd10, 3'd0, 5'd10, 7'h13));
		end
		emit(32'h0080_05ef);
		emit(i_type(12'd1, 5'd10, 3'd0, 5'd10, 7'h13));
		// auipc then jalr to auipc+12 with bit 0 set in the offset
		emit({20'h0, 5'd12, 7'h17});
		emit(i_type(12'd13, 5'd12, 3'd0, 5'd13, 7'h67));
		emit(i_type(12'd1, 5'd10, 3'd0, 5'd10, 7'h13));
		emit(32'h0010_0073);
	endtask

	task automatic build_memory();
		emit({20'h1, 5'd5, 7'h37});
		load_const(5'd6, lcg_next());
		load_const(5'd7, lcg_next());
		emit(s_type(12'd0, 5'd6, 5'd5, 3'd2));
		for (int k = 0; k < 4; k++) begin
			emit(s_type(12'(4 + k), (k % 2 == 1) ? 5'd7 : 5'd6, 5'd5, 3'd0));
		end
		emit(s_type(12'd8, 5'd6, 5'd5, 3'd1));
		emit(s_type(12'd10, 5'd7, 5'd5, 3'd1));
		emit(s_type(12'd12, 5'd7, 5'd5, 3'd2));
		for (int k = 0; k < 4; k++) begin
			emit(i_type(12'(4 + k), 5'd5, 3'd0, 5'd8, 7'h03));
			emit(i_type(12'(4 + k), 5'd5, 3'd4, 5'd9, 7'h03));
		end
		emit(i_type(12'd8, 5'd5, 3'd1, 5'd10, 7'h03));
		emit(i_type(12'd8, 5'd5, 3'd5, 5'd11, 7'h03));
		emit(i_type(12'd10, 5'd5, 3'd1, 5'd12, 7'h03));
		emit(i_type(12'd10, 5'd5, 3'd5, 5'd13, 7'h03));
		emit(i_type(12'd0, 5'd5, 3'd2, 5'd14, 7'h03));
		emit(i_type(12'd12, 5'd5, 3'd2, 5'd15, 7'h03));
		// untouched words still hold the fill pattern
		emit(i_type(12'd17, 5'd5, 3'd0, 5'd16, 7'h03));
		emit(i_type(12'd19, 5'd5, 3'd4, 5'd17, 7'h03));
		emit(i_type(12'd18, 5'd5, 3'd1, 5'd18, 7'h03));
		emit(i_type(12'd22, 5'd5, 3'd5, 5'd19, 7'h03));
		emit(i_type(12'd24, 5'd5, 3'd2, 5'd20, 7'h03));
		emit(32'h0010_0073);
	endtask

	// handler sits at word 14
	task automatic build_csr();
		emit({20'h0, 5'd1, 7'h17});
		emit(i_type(12'd56, 5'd1, 3'd0, 5'd1, 7'h13));
		emit(i_type(rv_pkg::csr_mtvec, 5'd1, 3'd1, 5'd2, 7'h73));
		emit(i_type(rv_pkg::csr_mtvec, 5'd1, 3'd1, 5'd3, 7'h73));
		load_const(5'd4, lcg_next());
		emit(i_type(rv_pkg::csr_mstatus, 5'd4, 3'd1, 5'd5, 7'h73));
		emit(i_type(rv_pkg::csr_mstatus, 5'd1, 3'd2, 5'd6, 7'h73));
		emit(i_type(rv_pkg::csr_mstatus, 5'd0, 3'd2, 5'd7, 7'h73));
		emit(i_type(rv_pkg::csr_mcause, 5'd4, 3'd1, 5'd8, 7'h73));
		emit(i_type(rv_pkg::csr_mepc, 5'd4, 3'd1, 5'd9, 7'h73));
		emit(32'h0000_0073);
		emit(i_type(12'd1, 5'd0, 3'd0, 5'd20, 7'h13));
		emit(32'h0010_0073);
		emit(i_type(rv_pkg::csr_mtvec, 5'd0, 3'd2, 5'd13, 7'h73));
		emit(i_type(rv_pkg::csr_mepc, 5'd0, 3'd2, 5'd10, 7'h73));
		emit(i_type(rv_pkg::csr_mcause, 5'd0, 3'd2, 5'd11, 7'h73));
		emit(i_type(12'd4, 5'd10, 3'd0, 5'd12, 7'h13));
		emit(i_type(rv_pkg::csr_mepc, 5'd12, 3'd1, 5'd0, 7'h73));
		emit(32'h3020_0073);
	endtask

	initial begin
		#(watchdog_ns);
		$display("watchdog expired before all tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		arst_n    = 1'b0;
		rng_state = 32'h12dc757d;
		errors    = 0;
		checks    = 0;
		m_halted  = 1'b0;
		clear_program();
		// a store sits at the reset pc while arst_n is low
		emit(s_type(12'd0, 5'd0, 5'd0, 3'd2));
		emit(i_type(12'd1, 5'd0, 3'd0, 5'd1, 7'h13));
		emit(32'h0010_0073);
		run_test("reset");
		clear_program();
		build_arith();
		run_test("arith");
		clear_program();
		build_control();
		run_test("control");
		clear_program();
		build_memory();
		run_test("memory");
		clear_program();
		build_csr();
		run_test("csr");
		clear_program();
		emit(i_type(12'd7, 5'd0, 3'd0, 5'd1, 7'h13));
		emit(32'h0010_0073);
		// the store after ebreak must never reach memory
		emit(s_type(12'd0, 5'd1, 5'd0, 3'd2));
		run_test("halt");
		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sim.f
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/csr_file.sv
hdl/inst_decode.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/rv_core.sv
tests/tb_clock.sv
tests/tb_top.sv

//--- Makefile
TOP := tb_top

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
